// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat list.f)) include/dcache_defs.svh

.PHONY: all run clean

all: obj_dir/Vtb_dcache_tag

obj_dir/Vtb_dcache_tag: list.f $(SRCS)
	verilator --binary --assert -j 0 -f list.f --top-module tb_dcache_tag \
		-o Vtb_dcache_tag

run: obj_dir/Vtb_dcache_tag
	./obj_dir/Vtb_dcache_tag | tee sim.log
	grep -q -F '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== include/dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cache geometry
`define DC_WAYS   4
`define DC_SETS   64

// address split, tag | index | offset
`define DC_TAG_W  20
`define DC_IDX_W  6
`define DC_OFF_W  6

`endif

// ==== list.f ====
+incdir+include
source/dcache_pkg.sv
source/tagv_ram.sv
source/tagv_memory.sv
source/plru_tree.sv
source/dcache_tag_ctrl.sv
source/dcache_tag_top.sv
test/tb_dcache_tag.sv

// ==== source/dcache_pkg.sv ====
`include "dcache_defs.svh"

package dcache_pkg;

    // field view of a request address
    typedef struct packed {
        logic [`DC_TAG_W-1:0] tag;
        logic [`DC_IDX_W-1:0] idx;
        logic [`DC_OFF_W-1:0] off;
    } dc_addr_f_s;

    typedef union packed {
        logic [`DC_TAG_W+`DC_IDX_W+`DC_OFF_W-1:0] raw;
        dc_addr_f_s                                f;
    } dc_addr_u;

    typedef enum logic {
        op_lookup = 1'b0,
        op_inval  = 1'b1
    } dc_op_e;

    // one-hot way vector
    typedef logic [`DC_WAYS-1:0] dc_way_t;

    typedef struct packed {
        dc_op_e   op;
        dc_addr_u addr;
    } dc_req_s;

    typedef struct packed {
        logic                 hit;
        dc_way_t              way;
        logic                 evict_vld;
        logic [`DC_TAG_W-1:0] evict_tag;
    } dc_rsp_s;

endpackage

// ==== source/dcache_tag_ctrl.sv ====
`include "dcache_defs.svh"

module dcache_tag_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  dcache_pkg::dc_req_s  req,
    output logic                 rsp_valid,
    output dcache_pkg::dc_rsp_s  rsp,
    output dcache_pkg::dc_addr_u r_addr,
    output dcache_pkg::dc_addr_u w_addr,
    output dcache_pkg::dc_way_t  we,
    output logic                 set_vld,
    output dcache_pkg::dc_way_t  way_sel,
    input  dcache_pkg::dc_way_t  hit,
    input  dcache_pkg::dc_way_t  vld,
    input  logic [`DC_TAG_W-1:0] replace_tag,
    input  logic                 replace_vld,
    input  dcache_pkg::dc_way_t  plru_victim,
    output logic                 touch,
    output logic [`DC_IDX_W-1:0] touch_idx,
    output dcache_pkg::dc_way_t  touch_way
);
    import dcache_pkg::*;

    dc_req_s req_q;
    dc_way_t victim;
    logic    hit_any;
    logic    is_lookup;
    logic    evict;

    // ------------------------------------------------------------
    // request stage
    // ------------------------------------------------------------
    assign r_addr = req.addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        req_q <= req;
    end

    // ------------------------------------------------------------
    // response stage
    // ------------------------------------------------------------
    assign hit_any   = |hit;
    assign is_lookup = (req_q.op == op_lookup);

    // lowest invalid way first, tree otherwise
    always_comb begin
        victim = plru_victim;
        for (int i = `DC_WAYS - 1; i >= 0; i--) begin
            if (!vld[i]) begin
                victim    = '0;
                victim[i] = 1'b1;
            end
        end
    end

    assign way_sel = victim;

    // fill the victim on a lookup miss, clear the hit way on invalidate
    always_comb begin
        we = '0;
        if (rsp_valid) begin
            if (is_lookup && !hit_any) begin
                we = victim;
            end else if (!is_lookup) begin
                we = hit;
            end
        end
    end

    assign w_addr  = req_q.addr;
    assign set_vld = is_lookup;

    assign touch     = rsp_valid && is_lookup;
    assign touch_idx = req_q.addr.f.idx;
    assign touch_way = hit_any ? hit : victim;

    assign evict         = is_lookup && !hit_any && replace_vld;
    assign rsp.hit       = hit_any;
    assign rsp.way       = hit_any ? hit : victim;
    assign rsp.evict_vld = evict;
    assign rsp.evict_tag = evict ? replace_tag : '0;

    // with every way valid the tree has to name a single victim
    a_plru_victim_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && (&vld) |-> $onehot(plru_victim));

endmodule

// ==== source/dcache_tag_top.sv ====
`include "dcache_defs.svh"

module dcache_tag_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  dcache_pkg::dc_req_s req,
    output logic                rsp_valid,
    output dcache_pkg::dc_rsp_s rsp
);
    import dcache_pkg::*;

    dc_addr_u             r_addr;
    dc_addr_u             w_addr;
    dc_way_t              we;
    dc_way_t              way_sel;
    dc_way_t              hit;
    dc_way_t              vld;
    dc_way_t              plru_victim;
    dc_way_t              touch_way;
    logic                 set_vld;
    logic                 replace_vld;
    logic                 touch;
    logic [`DC_TAG_W-1:0] replace_tag;
    logic [`DC_IDX_W-1:0] touch_idx;

    dcache_tag_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .r_addr      (r_addr),
        .w_addr      (w_addr),
        .we          (we),
        .set_vld     (set_vld),
        .way_sel     (way_sel),
        .hit         (hit),
        .vld         (vld),
        .replace_tag (replace_tag),
        .replace_vld (replace_vld),
        .plru_victim (plru_victim),
        .touch       (touch),
        .touch_idx   (touch_idx),
        .touch_way   (touch_way)
    );

    tagv_memory u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .r_addr      (r_addr),
        .w_addr      (w_addr),
        .we          (we),
        .set_vld     (set_vld),
        .way_sel     (way_sel),
        .hit         (hit),
        .vld         (vld),
        .replace_tag (replace_tag),
        .replace_vld (replace_vld)
    );

    plru_tree u_plru (
        .clk       (clk),
        .rst_n     (rst_n),
        .r_idx     (r_addr.f.idx),
        .victim    (plru_victim),
        .touch     (touch),
        .touch_idx (touch_idx),
        .touch_way (touch_way)
    );

endmodule

// ==== source/plru_tree.sv ====
`include "dcache_defs.svh"

module plru_tree (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`DC_IDX_W-1:0] r_idx,
    output dcache_pkg::dc_way_t  victim,
    input  logic                 touch,
    input  logic [`DC_IDX_W-1:0] touch_idx,
    input  dcache_pkg::dc_way_t  touch_way
);
    // per set: b0 picks the half, b1 way0/way1, b2 way2/way3
    logic [`DC_SETS-1:0][2:0] state;
    logic [`DC_IDX_W-1:0]     idx_q;
    logic [2:0]               rd_bits;
    logic [2:0]               nxt_bits;

    // ------------------------------------------------------------
    // update on touch
    // ------------------------------------------------------------
    always_comb begin
        nxt_bits = state[touch_idx];
        if (touch_way[0] || touch_way[1]) begin
            nxt_bits[0] = 1'b1;
            nxt_bits[1] = touch_way[0];
        end else begin
            nxt_bits[0] = 1'b0;
            nxt_bits[2] = touch_way[2];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= '0;
            idx_q <= '0;
        end else begin
            idx_q <= r_idx;
            if (touch) begin
                state[touch_idx] <= nxt_bits;
            end
        end
    end

    // ------------------------------------------------------------
    // victim decode
    // ------------------------------------------------------------
    // state is read after the edge, so a touch that lands together
    // with the read is already visible here
    assign rd_bits = state[idx_q];

    always_comb begin
        if (!rd_bits[0]) begin
            victim = rd_bits[1] ? 4'b0010 : 4'b0001;
        end else begin
            victim = rd_bits[2] ? 4'b1000 : 4'b0100;
        end
    end

    a_touch_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        touch |-> $onehot(touch_way));

endmodule

// ==== source/tagv_memory.sv ====
`include "dcache_defs.svh"

module tagv_memory (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dcache_pkg::dc_addr_u r_addr,
    input  dcache_pkg::dc_addr_u w_addr,
    input  dcache_pkg::dc_way_t  we,
    input  logic                 set_vld,
    input  dcache_pkg::dc_way_t  way_sel,
    output dcache_pkg::dc_way_t  hit,
    output dcache_pkg::dc_way_t  vld,
    output logic [`DC_TAG_W-1:0] replace_tag,
    output logic                 replace_vld
);
    logic [`DC_TAG_W-1:0] tag_q;
    logic [`DC_TAG_W-1:0] rd_tag [`DC_WAYS];

    // request tag lines up with the registered RAM read
    always_ff @(posedge clk) begin
        tag_q <= r_addr.f.tag;
    end

    // ------------------------------------------------------------
    // ways
    // ------------------------------------------------------------
    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        tagv_ram u_ram (
            .clk     (clk),
            .rst_n   (rst_n),
            .w_idx   (w_addr.f.idx),
            .w_tag   (w_addr.f.tag),
            .we      (we[w]),
            .set_vld (set_vld),
            .r_idx   (r_addr.f.idx),
            .r_tag   (rd_tag[w]),
            .r_vld   (vld[w])
        );

        assign hit[w] = vld[w] && (rd_tag[w] == tag_q);
    end

    // ------------------------------------------------------------
    // victim readout
    // ------------------------------------------------------------
    always_comb begin
        case (way_sel)
            4'b0001: begin
                replace_tag = rd_tag[0];
                replace_vld = vld[0];
            end
            4'b0010: begin
                replace_tag = rd_tag[1];
                replace_vld = vld[1];
            end
            4'b0100: begin
                replace_tag = rd_tag[2];
                replace_vld = vld[2];
            end
            4'b1000: begin
                replace_tag = rd_tag[3];
                replace_vld = vld[3];
            end
            default: begin
                replace_tag = '0;
                replace_vld = 1'b0;
            end
        endcase
    end

    // a set never holds the same tag twice, so fills must keep ways unique
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(hit));

    a_we_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(we));

endmodule

// ==== source/tagv_ram.sv ====
`include "dcache_defs.svh"

module tagv_ram (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`DC_IDX_W-1:0] w_idx,
    input  logic [`DC_TAG_W-1:0] w_tag,
    input  logic                 we,
    input  logic                 set_vld,
    input  logic [`DC_IDX_W-1:0] r_idx,
    output logic [`DC_TAG_W-1:0] r_tag,
    output logic                 r_vld
);
    logic [`DC_TAG_W-1:0] tag_mem [`DC_SETS];
    logic [`DC_SETS-1:0]  vld_bits;
    logic                 fwd;

    // write and read on the same set this cycle, read sees the new entry
    assign fwd = we && (w_idx == r_idx);

    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[w_idx] <= w_tag;
        end
        r_tag <= fwd ? w_tag : tag_mem[r_idx];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_bits <= '0;
            r_vld    <= 1'b0;
        end else begin
            if (we) begin
                vld_bits[w_idx] <= set_vld;
            end
            r_vld <= fwd ? set_vld : vld_bits[r_idx];
        end
    end

endmodule

// ==== test/tb_dcache_tag.sv ====
`include "dcache_defs.svh"

module tb_dcache_tag;
    import dcache_pkg::*;

    localparam int TABLE_LEN    = 19;
    localparam int RAND_LEN     = 200;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = TABLE_LEN + RAND_LEN + RESET_CYCLES + 50;

    logic    clk;
    logic    rst_n;
    logic    req_valid;
    dc_req_s req;
    logic    rsp_valid;
    dc_rsp_s rsp;

    // reference copy of tags, valid bits and tree state
    logic                 m_vld  [`DC_SETS][`DC_WAYS];
    logic [`DC_TAG_W-1:0] m_tag  [`DC_SETS][`DC_WAYS];
    logic [2:0]           m_plru [`DC_SETS];

    dc_req_s reqs [$];
    dc_rsp_s exps [$];

    integer seed;
    int     cycles = 0;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     rand_bad = 0;

    dcache_tag_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    task automatic plru_touch(input logic [`DC_IDX_W-1:0] s, input int w);
        // point b0 at the other half, the half bit at the sibling
        if (w < 2) begin
            m_plru[s][0] = 1'b1;
            m_plru[s][1] = (w == 0);
        end else begin
            m_plru[s][0] = 1'b0;
            m_plru[s][2] = (w == 2);
        end
    endtask

    task automatic predict_rsp(input dc_req_s r, output dc_rsp_s e);
        logic [`DC_IDX_W-1:0] s;
        int                   hw;
        int                   vw;
        s  = r.addr.f.idx;
        hw = -1;
        vw = -1;
        e  = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (m_vld[s][w] && m_tag[s][w] == r.addr.f.tag)
                hw = w;
        end
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!m_vld[s][w])
                vw = w;
        end
        if (vw < 0)
            vw = m_plru[s][0] ? (m_plru[s][2] ? 3 : 2) : (m_plru[s][1] ? 1 : 0);
        if (hw >= 0) begin
            e.hit     = 1'b1;
            e.way[hw] = 1'b1;
            if (r.op == op_lookup)
                plru_touch(s, hw);
            else
                m_vld[s][hw] = 1'b0;
        end else begin
            e.way[vw] = 1'b1;
            if (r.op == op_lookup) begin
                e.evict_vld = m_vld[s][vw];
                if (m_vld[s][vw])
                    e.evict_tag = m_tag[s][vw];
                m_tag[s][vw] = r.addr.f.tag;
                m_vld[s][vw] = 1'b1;
                plru_touch(s, vw);
            end
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic add_vec(input dc_op_e op, input logic [31:0] addr, input logic hit,
                           input dc_way_t way, input logic ev,
                           input logic [`DC_TAG_W-1:0] ev_tag);
        dc_req_s r;
        dc_rsp_s e;
        dc_rsp_s model;
        r.op        = op;
        r.addr.raw  = addr;
        e.hit       = hit;
        e.way       = way;
        e.evict_vld = ev;
        e.evict_tag = ev_tag;
        // model follows along so the random phase starts in step
        predict_rsp(r, model);
        reqs.push_back(r);
        exps.push_back(e);
    endtask

    task automatic add_random();
        logic [31:0] rnd;
        dc_req_s     r;
        dc_rsp_s     e;
        rnd = $random(seed);
        r.op         = (rnd[12:11] == 2'b00) ? op_inval : op_lookup;
        r.addr.f.tag = {17'h0, rnd[2:0]};
        r.addr.f.idx = {4'h0, rnd[4:3]};
        r.addr.f.off = rnd[10:5];
        predict_rsp(r, e);
        reqs.push_back(r);
        exps.push_back(e);
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    task automatic check_rsp(input int n, input dc_rsp_s got, input dc_rsp_s exp,
                             output bit ok);
        ok = 1'b1;
        if (got.hit !== exp.hit) begin
            $display("Fail rsp.hit: got %h expected %h, request %0d", got.hit, exp.hit, n);
            ok = 1'b0;
        end
        if (got.way !== exp.way) begin
            $display("Fail rsp.way: got %h expected %h, request %0d", got.way, exp.way, n);
            ok = 1'b0;
        end
        if (got.evict_vld !== exp.evict_vld) begin
            $display("Fail rsp.evict_vld: got %h expected %h, request %0d",
                     got.evict_vld, exp.evict_vld, n);
            ok = 1'b0;
        end
        if (got.evict_tag !== exp.evict_tag) begin
            $display("Fail rsp.evict_tag: got %h expected %h, request %0d",
                     got.evict_tag, exp.evict_tag, n);
            ok = 1'b0;
        end
        if (!ok)
            errors++;
    endtask

    task automatic check_strobe(input int n, input logic got, input logic exp, output bit ok);
        ok = (got === exp);
        if (!ok) begin
            if (exp)
                $display("response strobe missing one cycle after request %0d", n);
            else
                $display("response strobe seen with no request before it (at %0d)", n);
            errors++;
        end
    endtask

    task automatic report_result(input int n, input bit ok);
        if (n < TABLE_LEN) begin
            tests_run++;
            if (!ok)
                tests_failed++;
            $display("test %2d  %s %08h : %s", n,
                     (reqs[n].op == op_inval) ? "inval " : "lookup",
                     reqs[n].addr.raw, ok ? "ok" : "mismatch");
        end else if (!ok) begin
            rand_bad++;
        end
    endtask

    initial begin
        bit ok_s;
        bit ok_r;
        seed      = 32'hcccd3295;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        for (int s = 0; s < `DC_SETS; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < `DC_WAYS; w++) begin
                m_vld[s][w] = 1'b0;
                m_tag[s][w] = '0;
            end
        end

        // address is tag[31:12] | set[11:6] | offset[5:0]
        add_vec(op_lookup, 32'habcdefc0, 1'b0, 4'b0001, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'habcdefe4, 1'b1, 4'b0001, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'h00001140, 1'b0, 4'b0001, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'h00002144, 1'b0, 4'b0010, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'h00003148, 1'b0, 4'b0100, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'h0000414c, 1'b0, 4'b1000, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'h0000117c, 1'b1, 4'b0001, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'h00002150, 1'b1, 4'b0010, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'h00003160, 1'b1, 4'b0100, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'h00004170, 1'b1, 4'b1000, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'h00005140, 1'b0, 4'b0001, 1'b1, 20'h00001);
        add_vec(op_lookup, 32'h00006140, 1'b0, 4'b0100, 1'b1, 20'h00003);
        add_vec(op_inval,  32'h00002140, 1'b1, 4'b0010, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'h00002148, 1'b0, 4'b0010, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'h0000217f, 1'b1, 4'b0010, 1'b0, 20'h00000);
        add_vec(op_inval,  32'h00009140, 1'b0, 4'b1000, 1'b0, 20'h00000);
        add_vec(op_inval,  32'h00006140, 1'b1, 4'b0100, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'h00007140, 1'b0, 4'b0100, 1'b0, 20'h00000);
        add_vec(op_lookup, 32'h00008140, 1'b0, 4'b0001, 1'b1, 20'h00005);
        repeat (RAND_LEN) add_random();

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // one request per cycle, each response checked in the cycle after
        for (int i = 0; i <= reqs.size(); i++) begin
            @(posedge clk);
            if (i < reqs.size()) begin
                req_valid <= 1'b1;
                req       <= reqs[i];
            end else begin
                req_valid <= 1'b0;
                req       <= '0;
            end
            @(negedge clk);
            if (i == 0) begin
                check_strobe(i, rsp_valid, 1'b0, ok_s);
            end else begin
                check_strobe(i - 1, rsp_valid, 1'b1, ok_s);
                check_rsp(i - 1, rsp, exps[i - 1], ok_r);
                report_result(i - 1, ok_s && ok_r);
            end
        end
        @(posedge clk);
        @(negedge clk);
        check_strobe(reqs.size(), rsp_valid, 1'b0, ok_s);

        tests_run++;
        if (rand_bad != 0)
            tests_failed++;
        $display("random phase  %0d requests : %0d mismatches", RAND_LEN, rand_bad);
        $display("summary  %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
